// File: hdl/mac_frame_pkg.sv
// 802.11 mac header field widths, frame types and byte positions, imported by the rx parser and channel access
package mac_frame_pkg;

  // field widths
  localparam int MAC_ADDR_W = 48;
  localparam int DURATION_W = 16;
  localparam int FC_W       = 16;
  localparam int BYTE_IDX_W = 16; // same width as the demod byte counter

  // frame control type field, bits 3:2 of the fc word
  typedef enum logic [1:0] {
    FRAME_MGMT = 2'b00,
    FRAME_CTRL = 2'b01,
    FRAME_DATA = 2'b10,
    FRAME_RSVD = 2'b11
  } frame_type_e;

  localparam int FC_TYPE_LSB = 2;

  // index of the last byte of each header field, counted from the first mac byte
  // fields arrive little-endian, lowest byte first
  localparam logic [BYTE_IDX_W-1:0] HDR_FC_LAST    = 16'd1;
  localparam logic [BYTE_IDX_W-1:0] HDR_DUR_LAST   = 16'd3;
  localparam logic [BYTE_IDX_W-1:0] HDR_ADDR1_LAST = 16'd9;

  // duration msb set means the field carries an aid, not a nav value
  localparam int DUR_AID_BIT = DURATION_W - 1;

endpackage

// File: hdl/xpu_timing_pkg.sv
// transmit-state encoding and timing widths shared by tx detection, channel access and the top level
package xpu_timing_pkg;

  // tx detection states
  // bb only: baseband running, rf rise still pending
  // bb rf: both busy
  // rf tail: baseband done, rf held for the analog tail
  typedef enum logic [1:0] {
    TX_IDLE    = 2'd0,
    TX_BB_ONLY = 2'd1,
    TX_BB_RF   = 2'd2,
    TX_RF_TAIL = 2'd3
  } tx_state_e;

  localparam int DELAY_W = 8; // bb to rf delay and rf tail, in clocks

  localparam int RSSI_HALF_DB_W = 11; // signed, 0.5 dB per lsb

endpackage

// File: hdl/phy_rx_parse.sv
// captures frame control, duration and receiver address from the demodulated byte stream of each rx frame
`timescale 1ns/10ps

module phy_rx_parse (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  pkt_header_valid_strobe_i,
  input  logic                                  byte_in_strobe_i,
  input  logic [7:0]                            byte_in_i,
  input  logic [mac_frame_pkg::BYTE_IDX_W-1:0]  byte_count_i,
  output mac_frame_pkg::frame_type_e            fc_type_o,
  output logic                                  fc_valid_o,
  output logic [mac_frame_pkg::DURATION_W-1:0]  duration_o,
  output logic [mac_frame_pkg::MAC_ADDR_W-1:0]  addr1_o,
  output logic                                  addr1_valid_o
);

  import mac_frame_pkg::*;

  logic [FC_W-1:0]       fc_q;
  logic [DURATION_W-1:0] dur_q;
  logic [MAC_ADDR_W-1:0] addr1_q;
  logic                  fc_valid_q;
  logic                  addr1_valid_q;

  logic in_fc;
  logic in_dur;
  logic in_addr1;

  // byte lane decode, fields are contiguous from byte 0
  assign in_fc    = (byte_count_i <= HDR_FC_LAST);
  assign in_dur   = (byte_count_i > HDR_FC_LAST) && (byte_count_i <= HDR_DUR_LAST);
  assign in_addr1 = (byte_count_i > HDR_DUR_LAST) && (byte_count_i <= HDR_ADDR1_LAST);

  // header strobe starts a fresh frame
  always_ff @(posedge clk) begin
    if (reset_i || pkt_header_valid_strobe_i) begin
      fc_valid_q    <= 1'b0;
      addr1_valid_q <= 1'b0;
    end else begin
      addr1_valid_q <= 1'b0; // single cycle strobe
      if (byte_in_strobe_i && (byte_count_i == HDR_FC_LAST)) begin
        fc_valid_q <= 1'b1; // held until next header
      end
      if (byte_in_strobe_i && (byte_count_i == HDR_ADDR1_LAST)) begin
        addr1_valid_q <= 1'b1;
      end
    end
  end

  // bytes enter at the top and shift down, so the first byte ends up lowest
  always_ff @(posedge clk) begin
    if (reset_i || pkt_header_valid_strobe_i) begin
      fc_q    <= '0;
      dur_q   <= '0;
      addr1_q <= '0;
    end else if (byte_in_strobe_i) begin
      if (in_fc) begin
        fc_q <= {byte_in_i, fc_q[FC_W-1:8]};
      end
      if (in_dur) begin
        dur_q <= {byte_in_i, dur_q[DURATION_W-1:8]};
      end
      if (in_addr1) begin
        addr1_q <= {byte_in_i, addr1_q[MAC_ADDR_W-1:8]};
      end
    end
  end

  assign fc_type_o     = frame_type_e'(fc_q[FC_TYPE_LSB +: $bits(frame_type_e)]);
  assign fc_valid_o    = fc_valid_q;
  assign duration_o    = dur_q;
  assign addr1_o       = addr1_q;
  assign addr1_valid_o = addr1_valid_q;

endmodule

// File: hdl/tx_on_detection.sv
// derives baseband-busy and rf-busy levels from the phy tx start and done strobes, rf delayed and extended
`timescale 1ns/10ps

module tx_on_detection (
  input  logic                               clk,
  input  logic                               reset_i,
  input  logic                               phy_tx_start_i,
  input  logic                               phy_tx_done_i,
  input  logic [xpu_timing_pkg::DELAY_W-1:0] bb_rf_delay_i,
  input  logic [xpu_timing_pkg::DELAY_W-1:0] rf_end_ext_i,
  output logic                               tx_bb_is_ongoing_o,
  output logic                               tx_rf_is_ongoing_o
);

  import xpu_timing_pkg::*;

  tx_state_e          state_q;
  tx_state_e          state_d;
  logic [DELAY_W-1:0] cnt_q; // shared by rf rise delay and rf tail
  logic [DELAY_W-1:0] cnt_d;
  logic               cnt_last;

  assign cnt_last = (cnt_q <= DELAY_W'(1));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= TX_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      TX_IDLE: begin
        if (phy_tx_start_i) begin
          if (bb_rf_delay_i == '0) begin
            state_d = TX_BB_RF; // rf together with bb
          end else begin
            state_d = TX_BB_ONLY;
            cnt_d   = bb_rf_delay_i;
          end
        end
      end
      TX_BB_ONLY: begin
        if (phy_tx_done_i) begin
          state_d = TX_IDLE; // rf never came up
        end else if (cnt_last) begin
          state_d = TX_BB_RF;
        end else begin
          cnt_d = cnt_q - DELAY_W'(1);
        end
      end
      TX_BB_RF: begin
        if (phy_tx_done_i) begin
          if (rf_end_ext_i == '0) begin
            state_d = TX_IDLE;
          end else begin
            state_d = TX_RF_TAIL;
            cnt_d   = rf_end_ext_i;
          end
        end
      end
      TX_RF_TAIL: begin
        // back-to-back tx, analog path is still up so rf stays on
        if (phy_tx_start_i) begin
          state_d = TX_BB_RF;
        end else if (cnt_last) begin
          state_d = TX_IDLE;
        end else begin
          cnt_d = cnt_q - DELAY_W'(1);
        end
      end
    endcase
  end

  assign tx_bb_is_ongoing_o = (state_q == TX_BB_ONLY) || (state_q == TX_BB_RF);
  assign tx_rf_is_ongoing_o = (state_q == TX_BB_RF) || (state_q == TX_RF_TAIL);

endmodule

// File: hdl/channel_access.sv
// nav timer, microsecond tick, own-address match and the registered channel idle decision
`timescale 1ns/10ps

module channel_access #(
  parameter int CLK_PER_US = 100
) (
  input  logic                                             clk,
  input  logic                                             reset_i,
  input  logic [mac_frame_pkg::MAC_ADDR_W-1:0]             addr1_i,
  input  logic                                             addr1_valid_i,
  input  logic [mac_frame_pkg::DURATION_W-1:0]             duration_i,
  input  logic [mac_frame_pkg::MAC_ADDR_W-1:0]             self_mac_addr_i,
  input  logic                                             fcs_in_strobe_i,
  input  logic                                             fcs_ok_i,
  input  logic                                             tx_rf_is_ongoing_i,
  input  logic                                             demod_is_ongoing_i,
  input  logic signed [xpu_timing_pkg::RSSI_HALF_DB_W-1:0] rssi_half_db_i,
  input  logic signed [xpu_timing_pkg::RSSI_HALF_DB_W-1:0] rssi_half_db_th_i,
  output logic                                             pkt_for_me_o,
  output logic                                             nav_busy_o,
  output logic                                             ch_idle_o
);

  import mac_frame_pkg::*;
  import xpu_timing_pkg::*;

  localparam int US_CNT_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;

  logic [US_CNT_W-1:0]   us_cnt_q;
  logic                  us_tick;
  logic                  pkt_for_me_q;
  logic                  other_pending_q; // addr1 seen for another station, fcs not yet
  logic [DURATION_W-1:0] nav_dur_q;
  logic [DURATION_W-1:0] nav_q;
  logic                  nav_load;
  logic                  rssi_low;
  logic                  ch_idle_q;

  assign us_tick = (us_cnt_q == US_CNT_W'(CLK_PER_US - 1));

  // only a good frame for someone else with a real duration value sets the nav,
  // and it never shortens a running nav
  assign nav_load = fcs_in_strobe_i && fcs_ok_i && other_pending_q &&
                    !nav_dur_q[DUR_AID_BIT] && (nav_dur_q > nav_q);

  // tick phase restarts on load so a nav of n lasts exactly n us
  always_ff @(posedge clk) begin
    if (reset_i || nav_load || us_tick) begin
      us_cnt_q <= '0;
    end else begin
      us_cnt_q <= us_cnt_q + US_CNT_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pkt_for_me_q    <= 1'b0;
      other_pending_q <= 1'b0;
    end else if (addr1_valid_i) begin
      pkt_for_me_q    <= (addr1_i == self_mac_addr_i);
      other_pending_q <= (addr1_i != self_mac_addr_i);
    end else if (fcs_in_strobe_i) begin
      other_pending_q <= 1'b0; // frame over, good or bad
    end
  end

  always_ff @(posedge clk) begin
    if (addr1_valid_i) begin
      nav_dur_q <= duration_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      nav_q <= '0;
    end else if (nav_load) begin
      nav_q <= nav_dur_q;
    end else if (us_tick && (nav_q != '0)) begin
      nav_q <= nav_q - DURATION_W'(1);
    end
  end

  assign rssi_low = (rssi_half_db_i < rssi_half_db_th_i); // signed compare

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ch_idle_q <= 1'b0;
    end else begin
      ch_idle_q <= !tx_rf_is_ongoing_i && !demod_is_ongoing_i && rssi_low && (nav_q == '0);
    end
  end

  assign pkt_for_me_o = pkt_for_me_q;
  assign nav_busy_o   = (nav_q != '0);
  assign ch_idle_o    = ch_idle_q;

endmodule

// File: hdl/xpu_lite.sv
// top level of the reduced lower mac, connects rx header parsing, tx state detection and channel access
`timescale 1ns/10ps

module xpu_lite #(
  parameter int CLK_PER_US = 100
) (
  input  logic                                             clk,
  input  logic                                             reset_i,
  // rx byte stream from the demodulator
  input  logic                                             pkt_header_valid_strobe_i,
  input  logic                                             byte_in_strobe_i,
  input  logic [7:0]                                       byte_in_i,
  input  logic [mac_frame_pkg::BYTE_IDX_W-1:0]             byte_count_i,
  input  logic                                             fcs_in_strobe_i,
  input  logic                                             fcs_ok_i,
  input  logic                                             demod_is_ongoing_i,
  input  logic signed [xpu_timing_pkg::RSSI_HALF_DB_W-1:0] rssi_half_db_i,
  // phy tx strobes
  input  logic                                             phy_tx_start_i,
  input  logic                                             phy_tx_done_i,
  // configuration
  input  logic [xpu_timing_pkg::DELAY_W-1:0]               bb_rf_delay_i,
  input  logic [xpu_timing_pkg::DELAY_W-1:0]               rf_end_ext_i,
  input  logic [mac_frame_pkg::MAC_ADDR_W-1:0]             self_mac_addr_i,
  input  logic signed [xpu_timing_pkg::RSSI_HALF_DB_W-1:0] rssi_half_db_th_i,
  // status
  output logic                                             tx_bb_is_ongoing_o,
  output logic                                             tx_rf_is_ongoing_o,
  output logic                                             mute_adc_o,
  output mac_frame_pkg::frame_type_e                       fc_type_o,
  output logic                                             fc_valid_o,
  output logic [mac_frame_pkg::MAC_ADDR_W-1:0]             addr1_o,
  output logic                                             pkt_for_me_o,
  output logic                                             nav_busy_o,
  output logic                                             ch_idle_o
);

  import mac_frame_pkg::*;

  logic [DURATION_W-1:0] duration;
  logic                  addr1_valid;

  phy_rx_parse phy_rx_parse_i (
    .clk                       (clk),
    .reset_i                   (reset_i),
    .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
    .byte_in_strobe_i          (byte_in_strobe_i),
    .byte_in_i                 (byte_in_i),
    .byte_count_i              (byte_count_i),
    .fc_type_o                 (fc_type_o),
    .fc_valid_o                (fc_valid_o),
    .duration_o                (duration),
    .addr1_o                   (addr1_o),
    .addr1_valid_o             (addr1_valid)
  );

  tx_on_detection tx_on_detection_i (
    .clk                (clk),
    .reset_i            (reset_i),
    .phy_tx_start_i     (phy_tx_start_i),
    .phy_tx_done_i      (phy_tx_done_i),
    .bb_rf_delay_i      (bb_rf_delay_i),
    .rf_end_ext_i       (rf_end_ext_i),
    .tx_bb_is_ongoing_o (tx_bb_is_ongoing_o),
    .tx_rf_is_ongoing_o (tx_rf_is_ongoing_o)
  );

  channel_access #(
    .CLK_PER_US (CLK_PER_US)
  ) channel_access_i (
    .clk                (clk),
    .reset_i            (reset_i),
    .addr1_i            (addr1_o),
    .addr1_valid_i      (addr1_valid),
    .duration_i         (duration),
    .self_mac_addr_i    (self_mac_addr_i),
    .fcs_in_strobe_i    (fcs_in_strobe_i),
    .fcs_ok_i           (fcs_ok_i),
    .tx_rf_is_ongoing_i (tx_rf_is_ongoing_o),
    .demod_is_ongoing_i (demod_is_ongoing_i),
    .rssi_half_db_i     (rssi_half_db_i),
    .rssi_half_db_th_i  (rssi_half_db_th_i),
    .pkt_for_me_o       (pkt_for_me_o),
    .nav_busy_o         (nav_busy_o),
    .ch_idle_o          (ch_idle_o)
  );

  assign mute_adc_o = tx_rf_is_ongoing_o; // own tx leaks into the rx adc

endmodule

// File: test/xpu_lite_properties.sv
// concurrent checks on the xpu_lite status outputs, attached to every xpu_lite by the bind below
`timescale 1ns/10ps

module xpu_lite_properties (
  input logic clk,
  input logic reset_i,
  input logic tx_start_i,
  input logic tx_done_i,
  input logic tx_bb_i,
  input logic tx_rf_i,
  input logic hdr_strobe_i,
  input logic fc_valid_i,
  input logic pkt_for_me_i,
  input logic demod_i,
  input logic nav_busy_i,
  input logic ch_idle_i
);

  int fail_cnt = 0; // summed into the testbench error count

  // start while baseband is down brings bb up next cycle
  a_bb_rise: assert property (@(posedge clk) disable iff (reset_i)
                              (tx_start_i && !tx_bb_i) |=> tx_bb_i)
    else begin
      fail_cnt++;
      $error("bb did not rise after tx start");
    end

  a_bb_fall: assert property (@(posedge clk) disable iff (reset_i)
                              (tx_done_i && tx_bb_i) |=> !tx_bb_i)
    else begin
      fail_cnt++;
      $error("bb did not fall after tx done");
    end

  a_busy_not_idle: assert property (@(posedge clk) disable iff (reset_i)
                                    (tx_rf_i || demod_i || nav_busy_i) |=> !ch_idle_i)
    else begin
      fail_cnt++;
      $error("channel reported idle while busy");
    end

  a_fc_valid_hold: assert property (@(posedge clk) disable iff (reset_i)
                                    (fc_valid_i && !hdr_strobe_i) |=> fc_valid_i)
    else begin
      fail_cnt++;
      $error("fc_valid dropped without a new header");
    end

  // sync reset clears every status level
  a_reset_clear: assert property (@(posedge clk) reset_i |=>
                                  !(tx_bb_i || tx_rf_i || fc_valid_i || pkt_for_me_i ||
                                    nav_busy_i || ch_idle_i))
    else begin
      fail_cnt++;
      $error("status not cleared by reset");
    end

endmodule

bind xpu_lite xpu_lite_properties xpu_lite_props (
  .clk          (clk),
  .reset_i      (reset_i),
  .tx_start_i   (phy_tx_start_i),
  .tx_done_i    (phy_tx_done_i),
  .tx_bb_i      (tx_bb_is_ongoing_o),
  .tx_rf_i      (tx_rf_is_ongoing_o),
  .hdr_strobe_i (pkt_header_valid_strobe_i),
  .fc_valid_i   (fc_valid_o),
  .pkt_for_me_i (pkt_for_me_o),
  .demod_i      (demod_is_ongoing_i),
  .nav_busy_i   (nav_busy_o),
  .ch_idle_i    (ch_idle_o)
);

// File: test/xpu_lite_tb.sv
// testbench for xpu_lite, runs tx timing, header parse, address match, nav, busy and reset tests
`timescale 1ns/10ps

module xpu_lite_tb;

  import mac_frame_pkg::*;
  import xpu_timing_pkg::*;

  localparam int CLK_PER_US = 10;
  localparam int TX_RUNS    = 3;
  // rough cycles per test
  localparam int LEN_RESET  = 10;
  localparam int LEN_TX     = TX_RUNS * 70;
  localparam int LEN_HDR    = 30;
  localparam int LEN_MATCH  = 60;
  localparam int LEN_NAV    = 16 * CLK_PER_US + 140; // longest nav is 16 us
  localparam int LEN_BUSY   = 60;
  localparam int MAX_CYCLES = 2 * (LEN_RESET + LEN_TX + LEN_HDR + LEN_MATCH + LEN_NAV + LEN_BUSY);
  localparam logic signed [RSSI_HALF_DB_W-1:0] RSSI_QUIET = -11'sd180;

  logic                             clk = 1'b0;
  logic                             reset_i;
  logic                             pkt_header_valid_strobe_i;
  logic                             byte_in_strobe_i;
  logic [7:0]                       byte_in_i;
  logic [BYTE_IDX_W-1:0]            byte_count_i;
  logic                             fcs_in_strobe_i;
  logic                             fcs_ok_i;
  logic                             demod_is_ongoing_i;
  logic signed [RSSI_HALF_DB_W-1:0] rssi_half_db_i;
  logic                             phy_tx_start_i;
  logic                             phy_tx_done_i;
  logic [DELAY_W-1:0]               bb_rf_delay_i;
  logic [DELAY_W-1:0]               rf_end_ext_i;
  logic [MAC_ADDR_W-1:0]            self_mac_addr_i;
  logic signed [RSSI_HALF_DB_W-1:0] rssi_half_db_th_i;
  logic                             tx_bb_is_ongoing_o;
  logic                             tx_rf_is_ongoing_o;
  logic                             mute_adc_o;
  frame_type_e                      fc_type_o;
  logic                             fc_valid_o;
  logic [MAC_ADDR_W-1:0]            addr1_o;
  logic                             pkt_for_me_o;
  logic                             nav_busy_o;
  logic                             ch_idle_o;

  logic [15:0] lfsr_state = 16'd48;
  logic [7:0]  hdr_bytes [0:9]; // fc, duration, addr1
  int          cycle_cnt = 0;
  int          check_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start_errors = 0;

  xpu_lite #(.CLK_PER_US(CLK_PER_US)) DUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles, a test never finished", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[62:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      check_errors++;
      $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      check_errors++;
      $display("check failed at %0t: %s", $time, what);
    end
  endtask

  function automatic int total_errors();
    return check_errors + DUT.xpu_lite_props.fail_cnt;
  endfunction

  task automatic report_test(input string name);
    int errs;
    errs = total_errors() - test_start_errors;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
    test_start_errors = total_errors();
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!ch_idle_o && n < 4 * CLK_PER_US) begin
      @(negedge clk);
      n++;
    end
    check_true(ch_idle_o, "channel never went idle");
  endtask

  // call right after driving the busy source
  task automatic expect_busy_within(input int max_cycles, input string source);
    int n;
    n = 0;
    while (ch_idle_o && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    check_true(!ch_idle_o, {source, " did not drop ch_idle_o in time"});
  endtask

  task automatic check_cleared(input logic with_idle);
    check_value("tx_bb_is_ongoing_o", 64'(tx_bb_is_ongoing_o), 64'(0));
    check_value("tx_rf_is_ongoing_o", 64'(tx_rf_is_ongoing_o), 64'(0));
    check_value("fc_valid_o", 64'(fc_valid_o), 64'(0));
    check_value("pkt_for_me_o", 64'(pkt_for_me_o), 64'(0));
    check_value("nav_busy_o", 64'(nav_busy_o), 64'(0));
    if (with_idle) begin
      check_value("ch_idle_o", 64'(ch_idle_o), 64'(0));
    end
  endtask

  // little-endian fields, lowest byte first
  task automatic build_header(input logic [15:0] fc, input logic [15:0] dur,
                              input logic [47:0] addr);
    hdr_bytes[0] = fc[7:0];
    hdr_bytes[1] = fc[15:8];
    hdr_bytes[2] = dur[7:0];
    hdr_bytes[3] = dur[15:8];
    for (int i = 0; i < 6; i++) begin
      hdr_bytes[4 + i] = addr[8*i +: 8];
    end
  endtask

  task automatic send_header();
    pkt_header_valid_strobe_i = 1'b1;
    @(negedge clk);
    pkt_header_valid_strobe_i = 1'b0;
    for (int i = 0; i < 10; i++) begin
      byte_in_strobe_i = 1'b1;
      byte_in_i        = hdr_bytes[i];
      byte_count_i     = BYTE_IDX_W'(i);
      @(negedge clk);
      check_value("fc_valid_o", 64'(fc_valid_o), 64'(i >= 1));
    end
    byte_in_strobe_i = 1'b0;
    @(negedge clk); // pkt_for_me_o lags addr1_valid by one cycle
  endtask

  task automatic send_fcs(input logic ok);
    fcs_in_strobe_i = 1'b1;
    fcs_ok_i        = ok;
    @(negedge clk);
    fcs_in_strobe_i = 1'b0;
    fcs_ok_i        = 1'b0;
  endtask

  task automatic run_tx_test();
    logic [63:0] r;
    int delay;
    int ext;
    int n;
    for (int run = 0; run < TX_RUNS; run++) begin
      draw_bits(4, r);
      delay = int'(r);
      draw_bits(4, r);
      ext = int'(r);
      bb_rf_delay_i = DELAY_W'(delay);
      rf_end_ext_i  = DELAY_W'(ext);
      phy_tx_start_i = 1'b1;
      @(negedge clk);
      phy_tx_start_i = 1'b0;
      check_value("tx_bb_is_ongoing_o", 64'(tx_bb_is_ongoing_o), 64'(1));
      n = 0;
      while (!tx_rf_is_ongoing_o && n < 300) begin
        @(negedge clk);
        n++;
      end
      check_value("tx_rf_is_ongoing_o rise delay", 64'(n), 64'(delay));
      check_value("mute_adc_o", 64'(mute_adc_o), 64'(1));
      repeat (3 + run) @(negedge clk);
      phy_tx_done_i = 1'b1;
      @(negedge clk);
      phy_tx_done_i = 1'b0;
      check_value("tx_bb_is_ongoing_o", 64'(tx_bb_is_ongoing_o), 64'(0));
      n = 0;
      while (tx_rf_is_ongoing_o && n < 300) begin
        @(negedge clk);
        n++;
      end
      check_value("tx_rf_is_ongoing_o tail", 64'(n), 64'(ext));
      check_value("mute_adc_o", 64'(mute_adc_o), 64'(0));
    end
  endtask

  task automatic run_nav_test(input logic [47:0] other);
    logic [63:0] r;
    int dur;
    int n;
    draw_bits(4, r);
    dur = int'(r) + 1; // 1 to 16 us
    wait_idle();
    build_header(16'h0008, 16'(dur), other);
    send_header();
    send_fcs(1'b1);
    check_value("nav_busy_o", 64'(nav_busy_o), 64'(1));
    expect_busy_within(2, "nav load");
    n = 0;
    while (!ch_idle_o && n < (dur + 2) * CLK_PER_US) begin
      @(negedge clk);
      n++;
    end
    check_true(n >= dur * CLK_PER_US && n <= (dur + 1) * CLK_PER_US,
               $sformatf("ch_idle_o low for %0d cycles with a nav of %0d us", n, dur));
    // own frame with good fcs, then foreign frame with bad fcs
    for (int k = 0; k < 2; k++) begin
      build_header(16'h0008, 16'(dur), (k == 0) ? self_mac_addr_i : other);
      send_header();
      send_fcs(k == 1 ? 1'b0 : 1'b1);
      repeat (3) begin
        check_value("nav_busy_o", 64'(nav_busy_o), 64'(0));
        @(negedge clk);
      end
    end
  endtask

  initial begin
    logic [63:0] r;
    logic [47:0] other;
    logic [15:0] fc;
    reset_i                   = 1'b1;
    pkt_header_valid_strobe_i = 1'b0;
    byte_in_strobe_i          = 1'b0;
    byte_in_i                 = '0;
    byte_count_i              = '0;
    fcs_in_strobe_i           = 1'b0;
    fcs_ok_i                  = 1'b0;
    demod_is_ongoing_i        = 1'b0;
    rssi_half_db_i            = RSSI_QUIET;
    rssi_half_db_th_i         = -11'sd120; // -60 dBm
    phy_tx_start_i            = 1'b0;
    phy_tx_done_i             = 1'b0;
    bb_rf_delay_i             = '0;
    rf_end_ext_i              = '0;
    draw_bits(48, r);
    self_mac_addr_i = r[47:0];

    repeat (5) begin
      @(negedge clk);
      check_cleared(1'b1);
    end
    reset_i = 1'b0;
    @(negedge clk);
    check_cleared(1'b0);
    report_test("reset state");

    run_tx_test();
    report_test("transmit timing");

    draw_bits(16, r);
    fc = r[15:0];
    draw_bits(48, r);
    other = r[47:0];
    build_header(fc, 16'h1234, other);
    send_header();
    check_value("fc_type_o", 64'(fc_type_o), 64'(fc[3:2])); // type sits in fc bits 3:2
    check_value("addr1_o", 64'(addr1_o), 64'(other));
    check_value("fc_valid_o", 64'(fc_valid_o), 64'(1));
    report_test("header parse");

    build_header(16'h0008, 16'h0000, self_mac_addr_i);
    send_header();
    check_value("pkt_for_me_o", 64'(pkt_for_me_o), 64'(1));
    other = self_mac_addr_i ^ {r[47:1], 1'b1}; // never equal to own address
    build_header(16'h0008, 16'h0000, other);
    send_header();
    check_value("pkt_for_me_o", 64'(pkt_for_me_o), 64'(0));
    report_test("address match");

    run_nav_test(other);
    report_test("nav");

    wait_idle();
    rssi_half_db_i = rssi_half_db_th_i + 11'sd4;
    expect_busy_within(2, "rssi above threshold");
    rssi_half_db_i = RSSI_QUIET;
    wait_idle();
    demod_is_ongoing_i = 1'b1;
    expect_busy_within(2, "demodulation");
    demod_is_ongoing_i = 1'b0;
    wait_idle();
    bb_rf_delay_i  = '0;
    rf_end_ext_i   = '0;
    phy_tx_start_i = 1'b1;
    @(negedge clk);
    phy_tx_start_i = 1'b0;
    expect_busy_within(1, "transmit");
    phy_tx_done_i = 1'b1;
    @(negedge clk);
    phy_tx_done_i = 1'b0;
    wait_idle();
    report_test("busy sources");

    $display("summary: %0d tests run, %0d failed, %0d tb check errors, %0d assertion errors",
             tests_run, tests_failed, check_errors, DUT.xpu_lite_props.fail_cnt);
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: xpu_lite.f
hdl/mac_frame_pkg.sv
hdl/xpu_timing_pkg.sv
hdl/phy_rx_parse.sv
hdl/tx_on_detection.sv
hdl/channel_access.sv
hdl/xpu_lite.sv
test/xpu_lite_properties.sv
test/xpu_lite_tb.sv

// File: Makefile
# verilator build and run of the xpu_lite testbench
SIM = obj_dir/xpu_lite_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module xpu_lite_tb -f xpu_lite.f --Mdir obj_dir -o xpu_lite_sim

run: compile
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
